//--- verilog/nts_extractor_pkg.sv
// NTS extractor datapath package
// sizes, word and index types, FSM state encodings

package nts_extractor_pkg;

  //----------------------------------------
  // datapath sizes
  //----------------------------------------

  // number of engines behind the single mux
  localparam int ENGINES        = 4;
  // one FIFO word from an engine
  localparam int WORD_WIDTH     = 64;
  // tx memory depth is 2**BUF_ADDR_WIDTH words
  localparam int BUF_ADDR_WIDTH = 8;

  //----------------------------------------
  // types
  //----------------------------------------

  typedef logic [1:0]                engine_idx_t;
  typedef logic [WORD_WIDTH-1:0]     word_t;
  // address or word count into tx memory
  typedef logic [BUF_ADDR_WIDTH-1:0] buf_addr_t;
  // valid bytes in last word, 1..8
  typedef logic [3:0]                lwdv_t;
  // one bit per byte lane toward the MAC
  typedef logic [7:0]                mac_valid_t;

  // engine to buffer copy
  typedef enum logic [2:0] {
    MUX_IDLE, MUX_START, MUX_COPY, MUX_DONE, MUX_WAIT_TX
  } mux_state_t;

  // buffer to MAC emit
  typedef enum logic [2:0] {
    TX_IDLE, TX_START, TX_WAIT_ACK, TX_EMIT, TX_STOP
  } tx_state_t;

endpackage

//--- verilog/nts_api_pkg.sv
// NTS extractor register interface package
// address map, core identity and register word type

package nts_api_pkg;

  localparam int API_ADDR_WIDTH = 12;
  localparam logic [API_ADDR_WIDTH-1:0] API_ADDR_BASE = 12'h400;

  //----------------------------------------
  // register offsets from API_ADDR_BASE
  //----------------------------------------

  localparam logic [API_ADDR_WIDTH-1:0] ADDR_NAME0   = 12'h000;
  localparam logic [API_ADDR_WIDTH-1:0] ADDR_NAME1   = 12'h001;
  localparam logic [API_ADDR_WIDTH-1:0] ADDR_VERSION = 12'h002;
  localparam logic [API_ADDR_WIDTH-1:0] ADDR_DUMMY   = 12'h003;
  // offsets 0x0a, 0x0c, 0x20, 0x21, 0x30, 0x40, 0x41 stay reserved

  // "NTS-EXTR" in ascii
  localparam logic [63:0] CORE_NAME    = 64'h4e54_532d_4558_5452;
  // "0.06"
  localparam logic [31:0] CORE_VERSION = 32'h302e_3036;

  typedef logic [31:0] api_data_t;

endpackage

//--- verilog/nts_buf_if.sv
// tx buffer handshake between the engine mux and the tx side
// mux fills memory and raises ready, tx takes it with start, frees it with stop

`timescale 1ns/1ns

interface nts_buf_if
  import nts_extractor_pkg::*;
();

  // memory write port, mux side
  logic      wr_en;
  buf_addr_t wr_addr;
  word_t     wr_data;

  // complete packet held, length and lwdv valid with it
  logic      ready;
  buf_addr_t length;
  lwdv_t     lwdv;

  // one cycle pulses from tx
  logic      start;
  logic      stop;

  modport mux_mp (
    output wr_en, wr_addr, wr_data, ready, length, lwdv,
    input  start, stop
  );

  modport tx_mp (
    input  wr_en, wr_addr, wr_data, ready, length, lwdv,
    output start, stop
  );

endinterface

//--- verilog/nts_extractor_api.sv
// NTS extractor register block
// core name and version readback, one scratch register

`timescale 1ns/1ns

module nts_extractor_api
  import nts_api_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  logic                      i_api_cs,
  input  logic                      i_api_we,
  input  logic [API_ADDR_WIDTH-1:0] i_api_address,
  input  api_data_t                 i_api_write_data,
  output api_data_t                 o_api_read_data
);

  logic [API_ADDR_WIDTH-1:0] api_offset;
  logic                      dummy_we;
  api_data_t                 dummy_reg;

  // offset wraps outside the window, so only base..base+3 decode
  assign api_offset = i_api_address - API_ADDR_BASE;

  assign dummy_we = i_api_cs && i_api_we && (api_offset == ADDR_DUMMY);

  //----------------------------------------
  // read mux, same cycle
  //----------------------------------------

  always_comb begin
    o_api_read_data = '0;
    if (i_api_cs && !i_api_we) begin
      case (api_offset)
        ADDR_NAME0:   o_api_read_data = CORE_NAME[63:32];
        ADDR_NAME1:   o_api_read_data = CORE_NAME[31:0];
        ADDR_VERSION: o_api_read_data = CORE_VERSION;
        ADDR_DUMMY:   o_api_read_data = dummy_reg;
        // unused addresses read zero
        default:      o_api_read_data = '0;
      endcase
    end
  end

  //----------------------------------------
  // scratch register
  //----------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      dummy_reg <= '0;
    end else if (dummy_we) begin
      dummy_reg <= i_api_write_data;
    end
  end

endmodule

//--- verilog/nts_extractor_mux.sv
// NTS extractor engine mux
// picks a ready engine round-robin and copies its FIFO into the tx buffer

`timescale 1ns/1ns

module nts_extractor_mux
  import nts_extractor_pkg::*;
(
  input  logic                             i_clk,
  input  logic                             i_areset,
  input  logic [ENGINES-1:0]               i_engine_packet_available,
  output logic [ENGINES-1:0]               o_engine_packet_read,
  input  logic [ENGINES-1:0]               i_engine_fifo_empty,
  output logic [ENGINES-1:0]               o_engine_fifo_rd_start,
  input  logic [ENGINES-1:0]               i_engine_fifo_rd_valid,
  input  logic [ENGINES*WORD_WIDTH-1:0]    i_engine_fifo_rd_data,
  input  logic [ENGINES*$bits(lwdv_t)-1:0] i_engine_bytes_last_word,
  nts_buf_if.mux_mp                        bus
);

  mux_state_t         state;
  // engine being served, or the one served last
  engine_idx_t        sel_idx;
  engine_idx_t        pick_idx;
  engine_idx_t        cand_idx;
  logic               pick_valid;
  logic [ENGINES-1:0] sel_onehot;
  buf_addr_t          wr_cnt;
  lwdv_t              lwdv_reg;
  // tx has taken the buffer, stop is only honoured after this
  logic               tx_taken;
  logic               capture;

  //----------------------------------------
  // round-robin pick
  //----------------------------------------

  // search starts at the engine after sel_idx and wraps
  always_comb begin
    pick_valid = 1'b0;
    pick_idx   = sel_idx;
    cand_idx   = sel_idx;
    for (int i = 1; i <= ENGINES; i++) begin
      cand_idx = engine_idx_t'((int'(sel_idx) + i) % ENGINES);
      if (!pick_valid && i_engine_packet_available[cand_idx]) begin
        pick_valid = 1'b1;
        pick_idx   = cand_idx;
      end
    end
  end

  always_comb begin
    sel_onehot          = '0;
    sel_onehot[sel_idx] = 1'b1;
  end

  // words may arrive with gaps, any time after rd_start
  assign capture = ((state == MUX_START) || (state == MUX_COPY)) &&
                   i_engine_fifo_rd_valid[sel_idx];

  // per engine pulses
  assign o_engine_fifo_rd_start = (state == MUX_START) ? sel_onehot : '0;
  assign o_engine_packet_read   = (state == MUX_DONE)  ? sel_onehot : '0;

  //----------------------------------------
  // buffer side
  //----------------------------------------

  assign bus.wr_en   = capture;
  assign bus.wr_addr = wr_cnt;
  assign bus.wr_data = i_engine_fifo_rd_data[sel_idx*WORD_WIDTH +: WORD_WIDTH];
  // full buffer blocks further picks until stop
  assign bus.ready   = (state == MUX_WAIT_TX);
  assign bus.length  = wr_cnt;
  assign bus.lwdv    = lwdv_reg;

  //----------------------------------------
  // copy FSM
  //----------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state    <= MUX_IDLE;
      sel_idx  <= engine_idx_t'(ENGINES - 1);
      wr_cnt   <= '0;
      lwdv_reg <= '0;
      tx_taken <= 1'b0;
    end else begin
      // word count doubles as write address
      if (capture) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      case (state)
        MUX_IDLE: begin
          if (!bus.ready && pick_valid) begin
            sel_idx  <= pick_idx;
            lwdv_reg <= i_engine_bytes_last_word[pick_idx*$bits(lwdv_t) +: $bits(lwdv_t)];
            wr_cnt   <= '0;
            state    <= MUX_START;
          end
        end
        MUX_START: begin
          state <= MUX_COPY;
        end
        MUX_COPY: begin
          // empty means the last word has been delivered
          if (i_engine_fifo_empty[sel_idx]) begin
            state <= MUX_DONE;
          end
        end
        MUX_DONE: begin
          tx_taken <= 1'b0;
          state    <= MUX_WAIT_TX;
        end
        MUX_WAIT_TX: begin
          if (bus.start) begin
            tx_taken <= 1'b1;
          end
          if (bus.stop && tx_taken) begin
            state <= MUX_IDLE;
          end
        end
        default: begin
          state <= MUX_IDLE;
        end
      endcase
    end
  end

endmodule

//--- verilog/nts_extractor_tx.sv
// NTS extractor transmit side
// holds the packet memory and streams it to the MAC after its ack

`timescale 1ns/1ns

module nts_extractor_tx
  import nts_extractor_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_areset,
  nts_buf_if.tx_mp   bus,
  output logic       o_mac_tx_start,
  input  logic       i_mac_tx_ack,
  output mac_valid_t o_mac_tx_data_valid,
  output word_t      o_mac_tx_data
);

  tx_state_t  state;
  word_t      mem [0:2**BUF_ADDR_WIDTH-1];
  word_t      rd_data;
  // read address, counts 0..length while emitting
  buf_addr_t  rd_cnt;
  // word on the output this cycle, and whether it is the last
  logic       emit_q;
  logic       last_q;
  mac_valid_t last_mask;

  //----------------------------------------
  // packet memory
  //----------------------------------------

  // registered read, one cycle behind rd_cnt
  always_ff @(posedge i_clk) begin
    if (bus.wr_en) begin
      mem[bus.wr_addr] <= bus.wr_data;
    end
    rd_data <= mem[rd_cnt];
  end

  //----------------------------------------
  // emit FSM
  //----------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state  <= TX_IDLE;
      rd_cnt <= '0;
      emit_q <= 1'b0;
      last_q <= 1'b0;
    end else begin
      emit_q <= (state == TX_EMIT) && (rd_cnt != bus.length);
      last_q <= (state == TX_EMIT) && (rd_cnt == bus.length - 1'b1);
      case (state)
        TX_IDLE: begin
          if (bus.ready) begin
            state <= TX_START;
          end
        end
        TX_START: begin
          state <= TX_WAIT_ACK;
        end
        TX_WAIT_ACK: begin
          if (i_mac_tx_ack) begin
            rd_cnt <= '0;
            state  <= TX_EMIT;
          end
        end
        TX_EMIT: begin
          // extra cycle at rd_cnt == length lets the last word drain
          if (rd_cnt == bus.length) begin
            state <= TX_STOP;
          end else begin
            rd_cnt <= rd_cnt + 1'b1;
          end
        end
        TX_STOP: begin
          state <= TX_IDLE;
        end
        default: begin
          state <= TX_IDLE;
        end
      endcase
    end
  end

  // start goes to both the mux and the MAC
  assign bus.start      = (state == TX_START);
  assign o_mac_tx_start = (state == TX_START);
  // after the last word has left
  assign bus.stop       = (state == TX_STOP);

  //----------------------------------------
  // MAC data and byte mask
  //----------------------------------------

  assign o_mac_tx_data = rd_data;

  // low lwdv lanes set, lwdv of 8 gives all ones
  always_comb begin
    last_mask = mac_valid_t'((16'h1 << bus.lwdv) - 16'h1);
    if (!emit_q) begin
      o_mac_tx_data_valid = '0;
    end else if (last_q) begin
      o_mac_tx_data_valid = last_mask;
    end else begin
      o_mac_tx_data_valid = '1;
    end
  end

endmodule

//--- verilog/nts_extractor.sv
// NTS packet extractor top level
// round-robin engine mux, single tx buffer and MAC emit, plus id registers

`timescale 1ns/1ns

module nts_extractor
  import nts_extractor_pkg::*;
  import nts_api_pkg::*;
(
  input  logic                               i_clk,
  input  logic                               i_areset,

  // register interface
  input  logic                               i_api_cs,
  input  logic                               i_api_we,
  input  logic [API_ADDR_WIDTH-1:0]          i_api_address,
  input  api_data_t                          i_api_write_data,
  output api_data_t                          o_api_read_data,

  // engines, one bit or slice each
  input  logic [ENGINES-1:0]                 i_engine_packet_available,
  output logic [ENGINES-1:0]                 o_engine_packet_read,
  input  logic [ENGINES-1:0]                 i_engine_fifo_empty,
  output logic [ENGINES-1:0]                 o_engine_fifo_rd_start,
  input  logic [ENGINES-1:0]                 i_engine_fifo_rd_valid,
  input  logic [ENGINES*WORD_WIDTH-1:0]      i_engine_fifo_rd_data,
  input  logic [ENGINES*$bits(lwdv_t)-1:0]   i_engine_bytes_last_word,

  // MAC transmit
  output logic                               o_mac_tx_start,
  input  logic                               i_mac_tx_ack,
  output mac_valid_t                         o_mac_tx_data_valid,
  output word_t                              o_mac_tx_data
);

  // shared tx buffer handshake
  nts_buf_if buf_if ();

  nts_extractor_api api_i (
    .i_clk            ( i_clk            ),
    .i_areset         ( i_areset         ),
    .i_api_cs         ( i_api_cs         ),
    .i_api_we         ( i_api_we         ),
    .i_api_address    ( i_api_address    ),
    .i_api_write_data ( i_api_write_data ),
    .o_api_read_data  ( o_api_read_data  )
  );

  nts_extractor_mux mux_i (
    .i_clk                     ( i_clk                     ),
    .i_areset                  ( i_areset                  ),
    .i_engine_packet_available ( i_engine_packet_available ),
    .o_engine_packet_read      ( o_engine_packet_read      ),
    .i_engine_fifo_empty       ( i_engine_fifo_empty       ),
    .o_engine_fifo_rd_start    ( o_engine_fifo_rd_start    ),
    .i_engine_fifo_rd_valid    ( i_engine_fifo_rd_valid    ),
    .i_engine_fifo_rd_data     ( i_engine_fifo_rd_data     ),
    .i_engine_bytes_last_word  ( i_engine_bytes_last_word  ),
    .bus                       ( buf_if                    )
  );

  nts_extractor_tx tx_i (
    .i_clk               ( i_clk               ),
    .i_areset            ( i_areset            ),
    .bus                 ( buf_if              ),
    .o_mac_tx_start      ( o_mac_tx_start      ),
    .i_mac_tx_ack        ( i_mac_tx_ack        ),
    .o_mac_tx_data_valid ( o_mac_tx_data_valid ),
    .o_mac_tx_data       ( o_mac_tx_data       )
  );

endmodule

//--- bench/tb_engine_model.sv
// engine FIFO model for the extractor testbench
// one packet per engine, streamed after rd_start with random gaps

`timescale 1ns/1ns

module tb_engine_model
  import nts_extractor_pkg::*;
(
  input  logic                             i_clk,
  input  logic [ENGINES-1:0]               i_rd_start,
  input  logic [ENGINES-1:0]               i_packet_read,
  output logic [ENGINES-1:0]               o_available,
  output logic [ENGINES-1:0]               o_empty,
  output logic [ENGINES-1:0]               o_rd_valid,
  output logic [ENGINES*WORD_WIDTH-1:0]    o_rd_data,
  output logic [ENGINES*$bits(lwdv_t)-1:0] o_bytes_last_word
);

  word_t              word_q [ENGINES][$];
  logic [ENGINES-1:0] sending;
  // pulses seen mid cycle, acted on after the next edge
  logic [ENGINES-1:0] start_s;
  logic [ENGINES-1:0] read_s;

  initial begin
    o_available       = '0;
    o_empty           = '1;
    o_rd_valid        = '0;
    o_rd_data         = '0;
    o_bytes_last_word = '0;
    sending           = '0;
  end

  task automatic push_word(input int e, input word_t w);
    word_q[e].push_back(w);
  endtask

  // packet complete, announce it with its last word byte count
  task automatic make_available(input int e, input lwdv_t lwdv);
    o_bytes_last_word[e*$bits(lwdv_t) +: $bits(lwdv_t)] = lwdv;
    o_available[e] = 1'b1;
  endtask

  always @(negedge i_clk) begin
    start_s = i_rd_start;
    read_s  = i_packet_read;
  end

  always @(posedge i_clk) begin
    #1;
    for (int e = 0; e < ENGINES; e++) begin
      o_rd_valid[e] = 1'b0;
      if (read_s[e]) begin
        o_available[e] = 1'b0;
      end
      if (start_s[e]) begin
        sending[e] = 1'b1;
        o_empty[e] = 1'b0;
      end else if (sending[e]) begin
        if (word_q[e].size() == 0) begin
          // last word already out
          o_empty[e] = 1'b1;
          sending[e] = 1'b0;
        end else if ($urandom_range(3, 0) != 0) begin
          o_rd_valid[e] = 1'b1;
          o_rd_data[e*WORD_WIDTH +: WORD_WIDTH] = word_q[e].pop_front();
        end
      end
    end
  end

endmodule

//--- bench/tb_nts_extractor.sv
// NTS extractor testbench
// registers, single packet, round-robin order and random traffic with slow MAC ack

`timescale 1ns/1ns

module tb_nts_extractor
  import nts_extractor_pkg::*;
  import nts_api_pkg::*;
();

  localparam int MAX_CYCLES = 20000;

  logic                             i_clk;
  logic                             i_areset;
  logic                             i_api_cs;
  logic                             i_api_we;
  logic [API_ADDR_WIDTH-1:0]        i_api_address;
  api_data_t                        i_api_write_data;
  api_data_t                        o_api_read_data;
  logic [ENGINES-1:0]               eng_available;
  logic [ENGINES-1:0]               o_engine_packet_read;
  logic [ENGINES-1:0]               eng_empty;
  logic [ENGINES-1:0]               o_engine_fifo_rd_start;
  logic [ENGINES-1:0]               eng_rd_valid;
  logic [ENGINES*WORD_WIDTH-1:0]    eng_rd_data;
  logic [ENGINES*$bits(lwdv_t)-1:0] eng_lwdv;
  logic                             o_mac_tx_start;
  logic                             i_mac_tx_ack;
  mac_valid_t                       o_mac_tx_data_valid;
  word_t                            o_mac_tx_data;

  // scoreboard state
  word_t exp_word_q [ENGINES][$];
  int    exp_len_q  [ENGINES][$];
  lwdv_t exp_lwdv_q [ENGINES][$];
  int    served_q [$];
  int    exp_order [$];
  int    cur_eng;
  int    word_idx;
  int    cycles;
  int    check_errors;
  int    sb_errors;
  logic  in_flight;
  logic  seen_avail;

  tb_engine_model model_i (
    .i_clk             ( i_clk                  ),
    .i_rd_start        ( o_engine_fifo_rd_start ),
    .i_packet_read     ( o_engine_packet_read   ),
    .o_available       ( eng_available          ),
    .o_empty           ( eng_empty              ),
    .o_rd_valid        ( eng_rd_valid           ),
    .o_rd_data         ( eng_rd_data            ),
    .o_bytes_last_word ( eng_lwdv               )
  );

  nts_extractor dut_i (
    .i_clk                     ( i_clk                  ),
    .i_areset                  ( i_areset               ),
    .i_api_cs                  ( i_api_cs               ),
    .i_api_we                  ( i_api_we               ),
    .i_api_address             ( i_api_address          ),
    .i_api_write_data          ( i_api_write_data       ),
    .o_api_read_data           ( o_api_read_data        ),
    .i_engine_packet_available ( eng_available          ),
    .o_engine_packet_read      ( o_engine_packet_read   ),
    .i_engine_fifo_empty       ( eng_empty              ),
    .o_engine_fifo_rd_start    ( o_engine_fifo_rd_start ),
    .i_engine_fifo_rd_valid    ( eng_rd_valid           ),
    .i_engine_fifo_rd_data     ( eng_rd_data            ),
    .i_engine_bytes_last_word  ( eng_lwdv               ),
    .o_mac_tx_start            ( o_mac_tx_start         ),
    .i_mac_tx_ack              ( i_mac_tx_ack           ),
    .o_mac_tx_data_valid       ( o_mac_tx_data_valid    ),
    .o_mac_tx_data             ( o_mac_tx_data          )
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  //----------------------------------------
  // protocol assertions
  //----------------------------------------

  quiet_before_traffic: assert property (@(posedge i_clk)
    !seen_avail |-> (!o_mac_tx_start && o_engine_fifo_rd_start == '0 &&
                     o_engine_packet_read == '0 && o_mac_tx_data_valid == '0))
  else begin
    $display("CHECK FAILED: o_engine_fifo_rd_start=%h o_engine_packet_read=%h expected 0",
             $sampled(o_engine_fifo_rd_start), $sampled(o_engine_packet_read));
    $display("CHECK FAILED: o_mac_tx_start=%h o_mac_tx_data_valid=%h expected 0",
             $sampled(o_mac_tx_start), $sampled(o_mac_tx_data_valid));
    check_errors++;
  end

  // no engine may be started while the buffer is full
  no_rd_start_in_tx: assert property (@(posedge i_clk) disable iff (i_areset)
    in_flight |-> o_engine_fifo_rd_start == '0)
  else begin
    $display("CHECK FAILED: o_engine_fifo_rd_start got %h expected 0 during transmit",
             $sampled(o_engine_fifo_rd_start));
    check_errors++;
  end

  read_one_hot: assert property (@(posedge i_clk) $onehot0(o_engine_packet_read))
  else begin
    $display("CHECK FAILED: o_engine_packet_read got %h expected one hot",
             $sampled(o_engine_packet_read));
    check_errors++;
  end

  // memory read latency puts the first word two cycles after the ack
  first_word_after_ack: assert property (@(posedge i_clk) disable iff (i_areset)
    $past(i_mac_tx_ack, 2) |-> o_mac_tx_data_valid != '0)
  else begin
    $display("CHECK FAILED: o_mac_tx_data_valid got %h expected nonzero two cycles after ack",
             $sampled(o_mac_tx_data_valid));
    check_errors++;
  end

  //----------------------------------------
  // scoreboard sampled mid cycle
  //----------------------------------------

  // low n lanes of the last word
  function automatic mac_valid_t lane_mask(input lwdv_t n);
    mac_valid_t m;
    m = '0;
    for (int i = 0; i < 8; i++) begin
      if (i < n) m[i] = 1'b1;
    end
    return m;
  endfunction

  task automatic check_word();
    word_t      exp_w;
    mac_valid_t exp_mask;
    int         len;
    if (!in_flight || exp_word_q[cur_eng].size() == 0) begin
      $display("unexpected word on the MAC port outside a packet");
      sb_errors++;
    end else begin
      exp_w    = exp_word_q[cur_eng].pop_front();
      len      = exp_len_q[cur_eng][0];
      exp_mask = (word_idx == len - 1) ? lane_mask(exp_lwdv_q[cur_eng][0]) : '1;
      assert (o_mac_tx_data == exp_w) else begin
        $display("CHECK FAILED: o_mac_tx_data got %h expected %h", o_mac_tx_data, exp_w);
        sb_errors++;
      end
      assert (o_mac_tx_data_valid == exp_mask) else begin
        $display("CHECK FAILED: o_mac_tx_data_valid got %h expected %h",
                 o_mac_tx_data_valid, exp_mask);
        sb_errors++;
      end
      word_idx++;
      if (word_idx == len) begin
        void'(exp_len_q[cur_eng].pop_front());
        void'(exp_lwdv_q[cur_eng].pop_front());
        in_flight = 1'b0;
      end
    end
  endtask

  always @(negedge i_clk) begin
    if (!i_areset) begin
      if (eng_available != '0) seen_avail = 1'b1;
      for (int e = 0; e < ENGINES; e++) begin
        if (o_engine_packet_read[e]) begin
          cur_eng = e;
          served_q.push_back(e);
        end
      end
      if (o_mac_tx_start) begin
        in_flight = 1'b1;
        word_idx  = 0;
      end
      if (o_mac_tx_data_valid != '0) begin
        check_word();
      end else if (in_flight && word_idx > 0) begin
        $display("gap in the MAC word stream after word %0d", word_idx);
        sb_errors++;
      end
    end
  end

  // MAC ack after 1 to 5 cycles
  initial begin
    int d;
    forever begin
      @(negedge i_clk);
      if (o_mac_tx_start) begin
        d = $urandom_range(5, 1);
        repeat (d) @(posedge i_clk);
        #1 i_mac_tx_ack = 1'b1;
        @(posedge i_clk);
        #1 i_mac_tx_ack = 1'b0;
      end
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("errors: %0d assertion, %0d scoreboard", check_errors, sb_errors);
      $display("TEST FAILED");
      $finish;
    end
  end

  //----------------------------------------
  // stimulus tasks
  //----------------------------------------

  task automatic api_read_check(input logic [API_ADDR_WIDTH-1:0] offset,
                                input api_data_t exp);
    @(posedge i_clk);
    #1;
    i_api_cs      = 1'b1;
    i_api_we      = 1'b0;
    i_api_address = API_ADDR_BASE + offset;
    @(negedge i_clk);
    assert (o_api_read_data == exp) else begin
      $display("CHECK FAILED: o_api_read_data at %h got %h expected %h",
               i_api_address, o_api_read_data, exp);
      sb_errors++;
    end
    @(posedge i_clk);
    #1 i_api_cs = 1'b0;
  endtask

  task automatic api_write(input logic [API_ADDR_WIDTH-1:0] offset, input api_data_t d);
    @(posedge i_clk);
    #1;
    i_api_cs         = 1'b1;
    i_api_we         = 1'b1;
    i_api_address    = API_ADDR_BASE + offset;
    i_api_write_data = d;
    @(posedge i_clk);
    #1;
    i_api_cs = 1'b0;
    i_api_we = 1'b0;
  endtask

  // waits for the engine to be free, then hands it a new packet
  task automatic load_packet(input int e, input int len, input lwdv_t lwdv);
    word_t w;
    @(posedge i_clk);
    #1;
    while (eng_available[e]) begin
      @(posedge i_clk);
      #1;
    end
    for (int i = 0; i < len; i++) begin
      w = {$urandom, $urandom};
      model_i.push_word(e, w);
      exp_word_q[e].push_back(w);
    end
    exp_len_q[e].push_back(len);
    exp_lwdv_q[e].push_back(lwdv);
    model_i.make_available(e, lwdv);
  endtask

  task automatic wait_drained();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge i_clk);
      busy = in_flight || (eng_available != '0);
      for (int e = 0; e < ENGINES; e++) begin
        if (exp_word_q[e].size() != 0) busy = 1'b1;
      end
    end
    repeat (4) @(posedge i_clk);
  endtask

  task automatic check_order();
    if (served_q.size() != exp_order.size()) begin
      $display("CHECK FAILED: served packet count got %h expected %h",
               served_q.size(), exp_order.size());
      sb_errors++;
    end else begin
      for (int i = 0; i < served_q.size(); i++) begin
        assert (served_q[i] == exp_order[i]) else begin
          $display("CHECK FAILED: o_engine_packet_read order[%0d] got %h expected %h",
                   i, served_q[i], exp_order[i]);
          sb_errors++;
        end
      end
    end
    served_q.delete();
  endtask

  //----------------------------------------
  // main sequence
  //----------------------------------------

  initial begin
    api_data_t scratch;
    void'($urandom(39492));
    i_areset         = 1'b1;
    i_api_cs         = 1'b0;
    i_api_we         = 1'b0;
    i_api_address    = '0;
    i_api_write_data = '0;
    i_mac_tx_ack     = 1'b0;
    cycles           = 0;
    check_errors     = 0;
    sb_errors        = 0;
    in_flight        = 1'b0;
    seen_avail       = 1'b0;
    cur_eng          = 0;
    word_idx         = 0;
    repeat (10) @(posedge i_clk);
    #1 i_areset = 1'b0;

    // id registers as ascii text, scratch and unused addresses
    api_read_check(ADDR_NAME0, "NTS-");
    api_read_check(ADDR_NAME1, "EXTR");
    api_read_check(ADDR_VERSION, "0.06");
    api_read_check(ADDR_DUMMY, '0);
    scratch = $urandom;
    api_write(ADDR_DUMMY, scratch);
    api_read_check(ADDR_DUMMY, scratch);
    api_read_check(12'h004, '0);
    api_read_check(12'h020, '0);

    // engine 2 alone
    load_packet(2, 7, 5);
    wait_drained();
    exp_order = {2};
    check_order();

    // engine 3 next so that the full round starts at 0
    load_packet(3, 3, 8);
    wait_drained();
    served_q.delete();
    fork
      load_packet(0, 4, 1);
      load_packet(1, 2, 3);
      load_packet(2, 5, 8);
      load_packet(3, 1, 6);
    join
    wait_drained();
    exp_order = {0, 1, 2, 3};
    check_order();

    // only 1 and 3 with each reloaded once
    fork
      begin
        load_packet(1, 6, 2);
        load_packet(1, 3, 7);
      end
      begin
        load_packet(3, 2, 4);
        load_packet(3, 9, 8);
      end
    join
    wait_drained();
    exp_order = {1, 3, 1, 3};
    check_order();

    // random traffic
    repeat (12) begin
      load_packet($urandom_range(3, 0), $urandom_range(20, 1), lwdv_t'($urandom_range(8, 1)));
    end
    wait_drained();
    if (served_q.size() != 12) begin
      $display("random phase served %0d packets instead of 12", served_q.size());
      sb_errors++;
    end

    $display("errors: %0d assertion, %0d scoreboard", check_errors, sb_errors);
    if (check_errors + sb_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- nts_extractor.f
verilog/nts_extractor_pkg.sv
verilog/nts_api_pkg.sv
verilog/nts_buf_if.sv
verilog/nts_extractor_api.sv
verilog/nts_extractor_mux.sv
verilog/nts_extractor_tx.sv
verilog/nts_extractor.sv
bench/tb_engine_model.sv
bench/tb_nts_extractor.sv

//--- Makefile
# Verilator build and run for the NTS extractor testbench

VERILATOR ?= verilator
TOP       ?= tb_nts_extractor
FILELIST  ?= nts_extractor.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, pass if $(LOG) holds TEST OK"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
